//--- bench/ahb_mem_model.sv
`timescale 1ns/100ps

`include "cache_settings.svh"

module ahb_mem_model
    import ahb_pkg::*;
(
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  logic [`CACHE_ADDR_W-1:0] mem_haddr,
    input  htrans_e                  mem_htrans,
    output logic                     mem_hready,
    output logic [31:0]              mem_hrdata,
    output int                       burst_count
);

    logic [31:0]              lfsr;
    logic [31:0]              lfsr_mid;
    logic                     data_phase;
    logic [`CACHE_ADDR_W-1:0] data_addr;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    initial begin
        lfsr        = 32'hf773;
        mem_hready  = 1'b1;
        data_phase  = 1'b0;
        data_addr   = '0;
        burst_count = 0;
    end

    assign lfsr_mid = lfsr_step(lfsr);

    // word at byte address A is A xor a5a50000
    assign mem_hrdata = data_phase ? (data_addr ^ 32'ha5a5_0000) : '0;

    always @(posedge upstream_intf) begin
        if (!rst_n) begin
            lfsr       <= 32'hf773;
            mem_hready <= 1'b1;
            data_phase <= 1'b0;
        end else begin
            // wait state when two successive bits are both set
            mem_hready <= !(lfsr[0] && lfsr_mid[0]);
            lfsr       <= lfsr_step(lfsr_mid);
            if (mem_hready) begin
                data_phase <= (mem_htrans == NONSEQ || mem_htrans == SEQ);
                data_addr  <= mem_haddr;
                if (mem_htrans == NONSEQ) begin
                    burst_count <= burst_count + 1;
                end
            end
        end
    end

endmodule

//--- bench/cache_checker.sv
`timescale 1ns/100ps

`include "cache_settings.svh"

module cache_checker
    import ahb_pkg::*;
(
    input logic                     upstream_intf,
    input logic                     rst_n,
    input logic                     hready,
    input logic [`CACHE_ADDR_W-1:0] mem_haddr,
    input htrans_e                  mem_htrans,
    input hburst_e                  mem_hburst,
    input logic                     mem_hready
);

    int fail_count = 0;

    burst_type: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        mem_htrans == NONSEQ |-> mem_hburst == WRAP4)
    else begin
        fail_count++;
        $error("burst started with hburst %0d instead of WRAP4", mem_hburst);
    end

    seq_order: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        mem_htrans == SEQ |-> $past(mem_htrans) inside {NONSEQ, SEQ})
    else begin
        fail_count++;
        $error("SEQ beat without a preceding NONSEQ or SEQ");
    end

    // next beat stays inside the 16-byte block
    wrap_addr: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        mem_htrans == SEQ && $past(mem_hready) |->
            mem_haddr == {$past(mem_haddr[31:4]), $past(mem_haddr[3:2]) + 2'd1, 2'b00})
    else begin
        fail_count++;
        $error("SEQ address %h breaks the WRAP4 order", mem_haddr);
    end

    reset_state: assert property (@(posedge upstream_intf)
        !rst_n |=> (mem_htrans == IDLE && hready))
    else begin
        fail_count++;
        $error("bus not idle after reset");
    end

endmodule

//--- bench/cache_tb.sv
`timescale 1ns/100ps

`include "cache_settings.svh"

module cache_tb
    import ahb_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] word;
        int          bursts;
        logic        hit;
        logic        reset_first;
    } entry_t;

    logic                     upstream_intf;
    logic                     por_n;
    logic                     soft_rst_n;
    logic                     rst_n;
    logic [`CACHE_ADDR_W-1:0] haddr;
    htrans_e                  htrans;
    logic                     hready;
    logic [31:0]              hrdata;
    logic [`CACHE_ADDR_W-1:0] mem_haddr;
    htrans_e                  mem_htrans;
    hburst_e                  mem_hburst;
    logic                     mem_hready;
    logic [31:0]              mem_hrdata;
    int                       burst_count;

    entry_t stim_q[$];
    int     mismatches;
    int     timeouts;

    assign rst_n = por_n && soft_rst_n;

    clock_gen u_clk (.upstream_intf(upstream_intf), .rst_n(por_n));

    cache_top DUT (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hready        (hready),
        .hrdata        (hrdata),
        .mem_haddr     (mem_haddr),
        .mem_htrans    (mem_htrans),
        .mem_hburst    (mem_hburst),
        .mem_hready    (mem_hready),
        .mem_hrdata    (mem_hrdata)
    );

    ahb_mem_model u_mem (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .mem_haddr     (mem_haddr),
        .mem_htrans    (mem_htrans),
        .mem_hready    (mem_hready),
        .mem_hrdata    (mem_hrdata),
        .burst_count   (burst_count)
    );

    bind cache_top cache_checker u_checker (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .hready        (hready),
        .mem_haddr     (mem_haddr),
        .mem_htrans    (mem_htrans),
        .mem_hburst    (mem_hburst),
        .mem_hready    (mem_hready)
    );

    function automatic void add_entry(input logic [31:0] addr, input int bursts,
                                      input logic hit, input logic reset_first);
        entry_t e;
        e.addr        = addr;
        e.word        = addr ^ 32'ha5a5_0000;
        e.bursts      = bursts;
        e.hit         = hit;
        e.reset_first = reset_first;
        stim_q.push_back(e);
    endfunction

    // entered and left just after a rising edge
    task automatic read_word(input logic [31:0] addr, output logic [31:0] data,
                             output int cycles, output logic ok);
        int   n;
        logic seen;
        ok     = 1'b0;
        data   = '0;
        cycles = 0;
        n      = 0;
        seen   = 1'b0;
        haddr  = addr;
        htrans = NONSEQ;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge upstream_intf);
            seen = hready;
            @(posedge upstream_intf);
            #1;
            n++;
        end
        htrans = IDLE;
        if (!seen) begin
            $display("timeout at %0t: address phase of %h never accepted", $time, addr);
            return;
        end
        seen = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge upstream_intf);
            seen = hready;
            data = hrdata;
            cycles++;
            @(posedge upstream_intf);
            #1;
        end
        if (!seen) begin
            $display("timeout at %0t: data phase of %h never completed", $time, addr);
            return;
        end
        ok = 1'b1;
    endtask

    task automatic apply_reset();
        soft_rst_n = 1'b0;
        repeat (2) @(posedge upstream_intf);
        #1;
        soft_rst_n = 1'b1;
    endtask

    task automatic check_reset_state();
        @(negedge upstream_intf);
        if (hready !== 1'b1) begin
            $display("MISMATCH at %0t: hready is %b after reset", $time, hready);
            mismatches++;
        end
        if (mem_htrans !== IDLE) begin
            $display("MISMATCH at %0t: mem_htrans is %0d after reset", $time, mem_htrans);
            mismatches++;
        end
        @(posedge upstream_intf);
        #1;
    endtask

    initial begin
        entry_t      e;
        logic [31:0] data;
        int          cycles;
        logic        ok;
        logic        seen;
        int          n;
        int          asserts;
        haddr      = '0;
        htrans     = IDLE;
        soft_rst_n = 1'b1;
        mismatches = 0;
        timeouts   = 0;

        // cold miss, repeat, rest of the line
        add_entry(32'h0000_1234, 1, 1'b0, 1'b0);
        add_entry(32'h0000_1234, 1, 1'b1, 1'b0);
        add_entry(32'h0000_1230, 1, 1'b1, 1'b0);
        add_entry(32'h0000_1238, 1, 1'b1, 1'b0);
        add_entry(32'h0000_123c, 1, 1'b1, 1'b0);
        // same index, other tag, then back
        add_entry(32'h0000_5634, 2, 1'b0, 1'b0);
        add_entry(32'h0000_1234, 3, 1'b0, 1'b0);
        add_entry(32'h0000_1238, 3, 1'b1, 1'b0);
        add_entry(32'h0000_8008, 4, 1'b0, 1'b0);
        add_entry(32'h0001_00f0, 5, 1'b0, 1'b0);
        add_entry(32'h00ab_cdec, 6, 1'b0, 1'b0);
        add_entry(32'h8000_0104, 7, 1'b0, 1'b0);
        add_entry(32'h0000_800c, 7, 1'b1, 1'b0);
        // reset clears the valid bits
        add_entry(32'h0000_1238, 8, 1'b0, 1'b1);
        add_entry(32'h0000_123c, 8, 1'b1, 1'b0);

        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge upstream_intf);
            seen = por_n;
            @(posedge upstream_intf);
            #1;
            n++;
        end
        if (!seen) begin
            $display("timeout at %0t: power-on reset never released", $time);
            timeouts++;
        end else begin
            check_reset_state();
        end

        for (int i = 0; i < stim_q.size() && timeouts == 0; i++) begin
            e = stim_q[i];
            if (e.reset_first) begin
                apply_reset();
                check_reset_state();
            end
            read_word(e.addr, data, cycles, ok);
            if (!ok) begin
                timeouts++;
            end else begin
                if (data !== e.word) begin
                    $display("MISMATCH at %0t: read %h returned %h, expected %h",
                             $time, e.addr, data, e.word);
                    mismatches++;
                end
                if (e.hit && cycles != 1) begin
                    $display("MISMATCH at %0t: hit on %h took %0d cycles",
                             $time, e.addr, cycles);
                    mismatches++;
                end
                if (!e.hit && cycles < 2) begin
                    $display("MISMATCH at %0t: miss on %h had no wait state", $time, e.addr);
                    mismatches++;
                end
                if (burst_count != e.bursts) begin
                    $display("MISMATCH at %0t: burst count %0d after %h, expected %0d",
                             $time, burst_count, e.addr, e.bursts);
                    mismatches++;
                end
            end
        end

        asserts = DUT.u_checker.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, asserts);
        if (mismatches == 0 && timeouts == 0 && asserts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic upstream_intf,
    output logic rst_n
);

    initial begin
        upstream_intf = 1'b0;
        forever #5 upstream_intf = ~upstream_intf;
    end

    // held low across the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge upstream_intf);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- design/ahb_pkg.sv
`include "cache_settings.svh"

package ahb_pkg;

    // AHB-lite transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // AHB-lite burst type
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_e;

endpackage

//--- design/cache_ctrl.sv
`timescale 1ns/100ps

`include "cache_settings.svh"

module cache_ctrl
    import ahb_pkg::*;
    import cache_pkg::*;
(
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  logic [`CACHE_ADDR_W-1:0] haddr,
    input  htrans_e                  htrans,
    input  logic                     hit,
    input  logic                     fill_done,
    output logic                     hready,
    output index_t                   req_index,
    output tag_t                     req_tag,
    output offset_t                  req_offset,
    output logic                     fill_start
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        accept;

    // address phase taken on an active transfer while ready
    assign accept = hready && (htrans == NONSEQ || htrans == SEQ);

    // low only while a miss is outstanding
    always_comb begin
        case (state)
            ST_LOOKUP: hready = hit;
            ST_FILL:   hready = 1'b0;
            default:   hready = 1'b1;
        endcase
    end

    // first data-phase cycle of a miss
    assign fill_start = (state == ST_LOOKUP) && !hit;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (!hit) begin
                    state_nxt = ST_FILL;
                end else if (!accept) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_FILL: begin
                if (fill_done) begin
                    state_nxt = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                state_nxt = accept ? ST_LOOKUP : ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request fields stay put through fill and respond
    always_ff @(posedge upstream_intf) begin
        if (accept) begin
            req_offset <= haddr[2 +: OFFSET_W];
            req_index  <= haddr[2 + OFFSET_W +: INDEX_W];
            req_tag    <= haddr[`CACHE_ADDR_W-1 -: TAG_W];
        end
    end

endmodule

//--- design/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    localparam int WORD_W   = `CACHE_LINE_BITS / `CACHE_WORDS_PER_LINE;
    localparam int OFFSET_W = $clog2(`CACHE_WORDS_PER_LINE);
    localparam int INDEX_W  = $clog2(`CACHE_LINES);
    // two byte-select bits below the word offset
    localparam int TAG_W    = `CACHE_ADDR_W - INDEX_W - OFFSET_W - 2;

    typedef logic [INDEX_W-1:0]          index_t;
    typedef logic [OFFSET_W-1:0]         offset_t;
    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [`CACHE_LINE_BITS-1:0] line_t;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_LOOKUP  = 2'd1,
        ST_FILL    = 2'd2,
        ST_RESPOND = 2'd3
    } ctrl_state_e;

endpackage

//--- design/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address width on both buses
`define CACHE_ADDR_W 32

// capacity and line geometry
`define CACHE_BYTES 1024
`define CACHE_LINE_BITS 128

`define CACHE_WORDS_PER_LINE (`CACHE_LINE_BITS / 32)
`define CACHE_LINES (`CACHE_BYTES * 8 / `CACHE_LINE_BITS)

`endif

//--- design/cache_top.sv
`timescale 1ns/100ps

`include "cache_settings.svh"

module cache_top
    import ahb_pkg::*;
    import cache_pkg::*;
(
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    // upstream requester
    input  logic [`CACHE_ADDR_W-1:0] haddr,
    input  htrans_e                  htrans,
    output logic                     hready,
    output logic [WORD_W-1:0]        hrdata,
    // downstream memory
    output logic [`CACHE_ADDR_W-1:0] mem_haddr,
    output htrans_e                  mem_htrans,
    output hburst_e                  mem_hburst,
    input  logic                     mem_hready,
    input  logic [WORD_W-1:0]        mem_hrdata
);

    index_t  req_index;
    tag_t    req_tag;
    offset_t req_offset;
    logic    hit;
    logic    fill_start;
    logic    fill_done;
    line_t   fill_line;

    cache_ctrl u_ctrl (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hit           (hit),
        .fill_done     (fill_done),
        .hready        (hready),
        .req_index     (req_index),
        .req_tag       (req_tag),
        .req_offset    (req_offset),
        .fill_start    (fill_start)
    );

    line_store u_store (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .req_index     (req_index),
        .req_tag       (req_tag),
        .req_offset    (req_offset),
        .fill_done     (fill_done),
        .fill_line     (fill_line),
        .hit           (hit),
        .word          (hrdata)
    );

    // wrap4 master on the memory side
    line_fill u_fill (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .fill_start    (fill_start),
        .req_index     (req_index),
        .req_tag       (req_tag),
        .req_offset    (req_offset),
        .mem_hready    (mem_hready),
        .mem_hrdata    (mem_hrdata),
        .mem_haddr     (mem_haddr),
        .mem_htrans    (mem_htrans),
        .mem_hburst    (mem_hburst),
        .fill_line     (fill_line),
        .fill_done     (fill_done)
    );

endmodule

//--- design/line_fill.sv
`timescale 1ns/100ps

`include "cache_settings.svh"

module line_fill
    import ahb_pkg::*;
    import cache_pkg::*;
(
    input  logic                     upstream_intf,
    input  logic                     rst_n,
    input  logic                     fill_start,
    input  index_t                   req_index,
    input  tag_t                     req_tag,
    input  offset_t                  req_offset,
    input  logic                     mem_hready,
    input  logic [WORD_W-1:0]        mem_hrdata,
    output logic [`CACHE_ADDR_W-1:0] mem_haddr,
    output htrans_e                  mem_htrans,
    output hburst_e                  mem_hburst,
    output line_t                    fill_line,
    output logic                     fill_done
);

    localparam int BEATS  = `CACHE_WORDS_PER_LINE;
    localparam int BEAT_W = $clog2(BEATS + 1);

    logic              active;
    logic [BEAT_W-1:0] addr_beat;
    logic [BEAT_W-1:0] data_beat;
    offset_t           addr_lane;
    offset_t           data_lane;
    logic              addr_take;
    logic              data_take;
    logic              last_data;

    // offset adds modulo the line, giving the wrap inside the block
    assign addr_lane = req_offset + offset_t'(addr_beat);
    assign data_lane = req_offset + offset_t'(data_beat);

    assign mem_haddr = {req_tag, req_index, addr_lane, 2'b00};

    always_comb begin
        if (!active || addr_beat == BEAT_W'(BEATS)) begin
            mem_htrans = IDLE;
        end else if (addr_beat == '0) begin
            mem_htrans = NONSEQ;
        end else begin
            mem_htrans = SEQ;
        end
    end

    assign mem_hburst = active ? WRAP4 : SINGLE;

    // data phase pending whenever fewer data beats than address beats
    assign addr_take = mem_hready && (mem_htrans != IDLE);
    assign data_take = mem_hready && active && (data_beat < addr_beat);
    assign last_data = data_take && (data_beat == BEAT_W'(BEATS - 1));

    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            active    <= 1'b0;
            addr_beat <= '0;
            data_beat <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= last_data;
            if (fill_start) begin
                active    <= 1'b1;
                addr_beat <= '0;
                data_beat <= '0;
            end else begin
                if (addr_take) begin
                    addr_beat <= addr_beat + 1'b1;
                end
                if (data_take) begin
                    data_beat <= data_beat + 1'b1;
                end
                if (last_data) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // each returned word lands in its own lane
    always_ff @(posedge upstream_intf) begin
        if (data_take) begin
            fill_line[WORD_W * data_lane +: WORD_W] <= mem_hrdata;
        end
    end

endmodule

//--- design/line_store.sv
`timescale 1ns/100ps

`include "cache_settings.svh"

module line_store
    import cache_pkg::*;
(
    input  logic              upstream_intf,
    input  logic              rst_n,
    input  index_t            req_index,
    input  tag_t              req_tag,
    input  offset_t           req_offset,
    input  logic              fill_done,
    input  line_t             fill_line,
    output logic              hit,
    output logic [WORD_W-1:0] word
);

    logic [`CACHE_LINES-1:0] valid;
    tag_t                    tag_mem  [`CACHE_LINES];
    line_t                   data_mem [`CACHE_LINES];

    tag_t                    rd_tag;
    line_t                   rd_line;

    // read port follows the captured request
    assign rd_tag  = tag_mem[req_index];
    assign rd_line = data_mem[req_index];

    assign hit = valid[req_index] && (rd_tag == req_tag);

    // word lanes are packed low offset first
    assign word = rd_line[WORD_W * req_offset +: WORD_W];

    // only the valid bits are cleared, which is the flush
    always_ff @(posedge upstream_intf) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill_done) begin
            valid[req_index] <= 1'b1;
        end
    end

    // whole line replaced at once
    always_ff @(posedge upstream_intf) begin
        if (fill_done) begin
            tag_mem[req_index]  <= req_tag;
            data_mem[req_index] <= fill_line;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module cache_tb -o cache_sim

out=$(./obj_dir/cache_sim +verilator+error+limit+1000 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+design
design/ahb_pkg.sv
design/cache_pkg.sv
design/cache_ctrl.sv
design/line_store.sv
design/line_fill.sv
design/cache_top.sv
bench/clock_gen.sv
bench/ahb_mem_model.sv
bench/cache_checker.sv
bench/cache_tb.sv
